// ==== bench/tb_fog_top.sv ====
module tb_fog_top;

	timeunit 1ns;
	timeprecision 100ps;

	import fog_pkg::*;

	localparam int ADC_BIT      = 14;
	localparam int GAIN_SHIFT   = 4;
	localparam int HALF_TIMEOUT = 400;
	localparam int PERIODS      = 16;

	logic                      i_clk;
	logic                      i_rst_n;
	logic                      i_status;
	logic                      i_polarity;
	logic                      i_trig;
	logic [WORD_W-1:0]         i_wait_cnt;
	logic signed [WORD_W-1:0]  i_err_offset;
	logic signed [ADC_BIT-1:0] i_adc_data;
	logic [2:0]                i_avg_sel;
	logic signed [WORD_W-1:0]  o_err;
	logic                      o_step_sync;
	logic                      o_step_sync_dly;
	logic                      o_rate_sync;
	logic                      o_ramp_sync;
	logic signed [WORD_W-1:0]  o_rate;
	logic [15:0]               o_ramp;

	// reference model state
	logic [31:0] lfsr;
	logic        idle_chk;
	logic        ramp_wrapped;
	logic        high_half;
	int          exp_err;
	int          exp_rate;
	logic [15:0] exp_ramp;

	fog_top u_dut (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_status        (i_status),
		.i_polarity      (i_polarity),
		.i_trig          (i_trig),
		.i_wait_cnt      (i_wait_cnt),
		.i_err_offset    (i_err_offset),
		.i_adc_data      (i_adc_data),
		.i_avg_sel       (i_avg_sel),
		.o_err           (o_err),
		.o_step_sync     (o_step_sync),
		.o_step_sync_dly (o_step_sync_dly),
		.o_rate_sync     (o_rate_sync),
		.o_ramp_sync     (o_ramp_sync),
		.o_rate          (o_rate),
		.o_ramp          (o_ramp)
	);

	always #20 i_clk = ~i_clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	function automatic string mismatch_line(input string name, input int got, input int want);
		return $sformatf("Mismatch at %0d ns: %s is %0d, expected %0d", $time, name, got, want);
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic pulse_trig();
		@(posedge i_clk);
		i_trig <= 1'b1;
		@(posedge i_clk);
		i_trig <= 1'b0;
	endtask

	// every half ends with a ramp pulse
	task automatic wait_half_end(input string what);
		int           n;
		demod_state_e st;
		n = 0;
		@(posedge i_clk);
		while (!o_ramp_sync) begin
			n++;
			if (n >= HALF_TIMEOUT) begin
				st = u_dut.u_demod.state;
				fail_run($sformatf("Timeout: no ramp sync at the end of the %s, demodulator in %s",
					what, st.name()));
			end
			@(posedge i_clk);
		end
	endtask

	// ramp step uses the rate in effect at the ramp pulse
	task automatic advance_ramp();
		logic [16:0] sum;
		sum = {1'b0, exp_ramp} + {1'b0, exp_rate[15:0]};
		if (sum[16])
			ramp_wrapped = 1'b1;
		exp_ramp = sum[15:0];
	endtask

	task automatic run_half(input int lvl, input logic extra, input string what);
		@(posedge i_clk);
		i_adc_data <= lvl[ADC_BIT-1:0];
		pulse_trig();
		// lands in settle or acquisition and must be ignored
		if (extra)
			pulse_trig();
		wait_half_end(what);
		// keep model updates clear of the last checks of this half
		repeat (3) @(posedge i_clk);
	endtask

	task automatic run_period(input logic [2:0] sel, input logic pol, input int ofs,
		input int wait_cycles, input logic extra);
		logic [31:0] raw;
		int          lvl_l;
		int          lvl_h;
		int          diff;
		raw = take_bits(ADC_BIT);
		lvl_l = int'($signed(raw[ADC_BIT-1:0]));
		raw = take_bits(ADC_BIT);
		lvl_h = int'($signed(raw[ADC_BIT-1:0]));
		@(posedge i_clk);
		i_avg_sel    <= sel;
		i_polarity   <= pol;
		i_err_offset <= ofs;
		i_wait_cnt   <= wait_cycles;
		high_half = 1'b0;
		// low half leaves the rate alone
		advance_ramp();
		run_half(lvl_l, extra, "low half");
		diff = lvl_h + ofs - lvl_l;
		exp_err = pol ? -diff : diff;
		exp_rate = exp_rate + (exp_err >>> GAIN_SHIFT);
		high_half = 1'b1;
		advance_ramp();
		run_half(lvl_h, extra, "high half");
	endtask

	a_idle_sync: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		idle_chk |-> !(o_step_sync || o_step_sync_dly || o_rate_sync || o_ramp_sync))
		else fail_run("A sync pulse appeared while the loop was disabled");

	a_idle_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		idle_chk |-> o_err == 0)
		else fail_run(mismatch_line("o_err", o_err, 0));

	a_idle_rate: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		idle_chk |-> o_rate == 0)
		else fail_run(mismatch_line("o_rate", o_rate, 0));

	a_idle_ramp: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		idle_chk |-> o_ramp == 0)
		else fail_run(mismatch_line("o_ramp", int'(o_ramp), 0));

	a_err_value: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_step_sync |-> o_err == exp_err)
		else fail_run(mismatch_line("o_err", o_err, exp_err));

	// pulse train after the step pulse
	a_step_dly: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$past(o_step_sync) |-> o_step_sync_dly)
		else fail_run("step_sync_dly did not follow step_sync by one cycle");

	a_rate_after_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$past(o_step_sync, 2) |-> o_rate_sync)
		else fail_run("rate_sync did not follow step_sync by two cycles");

	a_ramp_after_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$past(o_step_sync, 3) |-> o_ramp_sync)
		else fail_run("ramp_sync did not follow step_sync by three cycles");

	a_ramp_after_rate: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$past(o_rate_sync) |-> (o_ramp_sync && !o_step_sync))
		else fail_run("rate_sync was not followed by a lone ramp_sync");

	// only the high half leads its rate pulse with a step pulse
	a_rate_source: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_rate_sync |-> ($past(o_step_sync, 2) == high_half))
		else fail_run("rate_sync came without a step pulse in the high half or with one in the low");

	a_rate_value: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$past(o_step_sync_dly) |-> o_rate == exp_rate)
		else fail_run(mismatch_line("o_rate", o_rate, exp_rate));

	a_ramp_value: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$past(o_ramp_sync) |-> o_ramp == exp_ramp)
		else fail_run(mismatch_line("o_ramp", int'(o_ramp), int'(exp_ramp)));

	initial begin
		logic [31:0] raw;
		logic        pol;
		int          ofs;
		int          wt;
		lfsr         = 32'h4f79;
		idle_chk     = 1'b1;
		ramp_wrapped = 1'b0;
		high_half    = 1'b0;
		exp_err      = 0;
		exp_rate     = 0;
		exp_ramp     = '0;
		i_clk        = 1'b0;
		i_rst_n      = 1'b0;
		i_status     = 1'b0;
		i_polarity   = 1'b0;
		i_trig       = 1'b0;
		i_wait_cnt   = '0;
		i_err_offset = '0;
		i_adc_data   = '0;
		i_avg_sel    = AVG_1;
		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;
		// disabled loop sees a trigger and a sample, nothing may move
		repeat (4) @(posedge i_clk);
		i_adc_data <= 14'sd1234;
		pulse_trig();
		repeat (6) @(posedge i_clk);
		idle_chk <= 1'b0;
		i_status <= 1'b1;
		repeat (4) @(posedge i_clk);
		// selector codes 0 to 7 twice, both polarities on each
		for (int p = 0; p < PERIODS; p++) begin
			pol = p[3] ^ p[0];
			raw = take_bits(18);
			ofs = int'($signed(raw[17:0]));
			raw = take_bits(4);
			wt = int'(raw[3:0]);
			run_period(3'(p % 8), pol, ofs, wt, (p % 3) == 1);
		end
		if (!ramp_wrapped) begin
			fail_run("The phase ramp never wrapped during the run");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// ==== fog_top.f ====
verilog/fog_pkg.sv
verilog/fog_avg_decode.sv
verilog/fog_err_demod.sv
verilog/fog_ramp_gen.sv
verilog/fog_top.sv
bench/tb_fog_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run tb_fog_top with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_fog_top -Mdir obj_dir -f fog_top.f > sim.log 2>&1 &&
	./obj_dir/Vtb_fog_top >> sim.log 2>&1
cat sim.log
grep -qx "All tests passed" sim.log && echo "simulation PASSED" || {
	echo "simulation FAILED"
	exit 1
}

// ==== verilog/fog_avg_decode.sv ====
module fog_avg_decode #(
	parameter int ADC_BIT = 14
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_status,
	input  logic                                  i_polarity,
	input  logic                                  i_trig,
	input  logic [fog_pkg::WORD_W-1:0]            i_wait_cnt,
	input  logic signed [fog_pkg::WORD_W-1:0]     i_err_offset,
	input  logic signed [ADC_BIT-1:0]             i_adc_data,
	input  fog_pkg::avg_sel_e                     i_avg_sel,
	output logic                                  o_status,
	output logic                                  o_polarity,
	output logic                                  o_trig,
	output logic [fog_pkg::WORD_W-1:0]            o_wait_cnt,
	output logic signed [fog_pkg::WORD_W-1:0]     o_err_offset,
	output logic signed [fog_pkg::WORD_W-1:0]     o_adc,
	output logic [6:0]                            o_avg_cnt,
	output logic [2:0]                            o_avg_shift
);

	import fog_pkg::*;

	avg_sel_e   r_avg_sel;
	logic [2:0] sel_code;

	// control inputs, one register stage
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_status     <= 1'b0;
			o_polarity   <= 1'b1;
			o_trig       <= 1'b0;
			o_wait_cnt   <= '0;
			o_err_offset <= '0;
			r_avg_sel    <= AVG_SEL_RST;
		end else begin
			o_status     <= i_status;
			o_polarity   <= i_polarity;
			o_trig       <= i_trig;
			o_wait_cnt   <= i_wait_cnt;
			o_err_offset <= i_err_offset;
			r_avg_sel    <= i_avg_sel;
		end
	end

	// sample word, sign bit replicated up to the data path width
	always_ff @(posedge i_clk) begin
		o_adc <= {{(WORD_W-ADC_BIT){i_adc_data[ADC_BIT-1]}}, i_adc_data};
	end

	// codes 7 and up behave as 64 samples
	always_comb begin
		if (r_avg_sel > AVG_SEL_MAX)
			sel_code = 3'(AVG_SEL_MAX);
		else
			sel_code = r_avg_sel;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_avg_cnt   <= 7'd1 << AVG_SEL_RST;
			o_avg_shift <= AVG_SEL_RST;
		end else begin
			o_avg_cnt   <= 7'd1 << sel_code;
			o_avg_shift <= sel_code;
		end
	end

	// the shift must divide the sum by exactly the sample count
	a_cnt_pow2: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_avg_cnt == (7'd1 << o_avg_shift))
		else $error("avg count %0d does not match shift %0d", o_avg_cnt, o_avg_shift);

endmodule

// ==== verilog/fog_err_demod.sv ====
module fog_err_demod (
	input  logic                                  i_clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_status,
	input  logic                                  i_polarity,
	input  logic                                  i_trig,
	input  logic [fog_pkg::WORD_W-1:0]            i_wait_cnt,
	input  logic signed [fog_pkg::WORD_W-1:0]     i_err_offset,
	input  logic signed [fog_pkg::WORD_W-1:0]     i_adc,
	input  logic [6:0]                            i_avg_cnt,
	input  logic [2:0]                            i_avg_shift,
	output logic signed [fog_pkg::WORD_W-1:0]     o_err,
	output logic                                  o_step_sync,
	output logic                                  o_step_sync_dly,
	output logic                                  o_rate_sync,
	output logic                                  o_ramp_sync
);

	import fog_pkg::*;

	demod_state_e state;
	demod_state_e state_nxt;

	// shared settle and sample down-counter
	logic [WORD_W-1:0]        cnt;
	logic                     cnt_zero;
	logic signed [WORD_W-1:0] acc;
	logic signed [WORD_W-1:0] avg_cur;
	logic signed [WORD_W-1:0] avg_l;
	logic signed [WORD_W-1:0] avg_h;
	logic signed [WORD_W-1:0] err_diff;

	assign cnt_zero = (cnt == '0);
	assign avg_cur  = acc >>> i_avg_shift;
	assign err_diff = avg_h - avg_l;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (i_status)
					state_nxt = WAIT_TRIG_L;
			end
			WAIT_TRIG_L: begin
				if (i_trig)
					state_nxt = SETTLE_L;
			end
			SETTLE_L: begin
				if (cnt_zero)
					state_nxt = ACQ_L;
			end
			ACQ_L: begin
				if (cnt_zero)
					state_nxt = RATE_PULSE_L;
			end
			RATE_PULSE_L: state_nxt = RAMP_PULSE_L;
			RAMP_PULSE_L: state_nxt = WAIT_TRIG_H;
			WAIT_TRIG_H: begin
				if (i_trig)
					state_nxt = SETTLE_H;
			end
			SETTLE_H: begin
				if (cnt_zero)
					state_nxt = ACQ_H;
			end
			ACQ_H: begin
				if (cnt_zero)
					state_nxt = ERR_GEN;
			end
			ERR_GEN:      state_nxt = ERR_GEN_DLY;
			ERR_GEN_DLY:  state_nxt = RATE_PULSE_H;
			RATE_PULSE_H: state_nxt = RAMP_PULSE_H;
			RAMP_PULSE_H: state_nxt = WAIT_TRIG_L;
			default:      state_nxt = IDLE;
		endcase
		// disabled loop parks in idle
		if (!i_status)
			state_nxt = IDLE;
	end

	// counter, accumulator and error word
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt   <= '0;
			acc   <= '0;
			o_err <= '0;
		end else begin
			case (state)
				IDLE: begin
					cnt <= '0;
					acc <= '0;
				end
				WAIT_TRIG_L, WAIT_TRIG_H: begin
					cnt <= i_wait_cnt;
					acc <= '0;
				end
				SETTLE_L, SETTLE_H: begin
					if (!cnt_zero)
						cnt <= cnt - 1'b1;
					else
						cnt <= WORD_W'(i_avg_cnt);
				end
				ACQ_L, ACQ_H: begin
					if (!cnt_zero) begin
						cnt <= cnt - 1'b1;
						acc <= acc + i_adc;
					end
				end
				ERR_GEN: begin
					// polarity set flips the sign
					if (i_polarity)
						o_err <= -err_diff;
					else
						o_err <= err_diff;
				end
				default: begin
				end
			endcase
		end
	end

	// half averages, stored on the last acquisition cycle
	always_ff @(posedge i_clk) begin
		if (state == ACQ_L && cnt_zero)
			avg_l <= avg_cur;
		if (state == ACQ_H && cnt_zero)
			avg_h <= avg_cur + i_err_offset;
	end

	// one-cycle pulse train, one state behind the fsm
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_step_sync     <= 1'b0;
			o_step_sync_dly <= 1'b0;
			o_rate_sync     <= 1'b0;
			o_ramp_sync     <= 1'b0;
		end else begin
			o_step_sync     <= (state == ERR_GEN);
			o_step_sync_dly <= (state == ERR_GEN_DLY);
			o_rate_sync     <= (state == RATE_PULSE_L) || (state == RATE_PULSE_H);
			o_ramp_sync     <= (state == RAMP_PULSE_L) || (state == RAMP_PULSE_H);
		end
	end

	a_sync_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0({o_step_sync, o_step_sync_dly, o_rate_sync, o_ramp_sync}))
		else $error("overlapping sync pulses");

	a_ramp_after_rate: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_ramp_sync |-> $past(o_rate_sync))
		else $error("ramp sync without rate sync on the previous cycle");

endmodule

// ==== verilog/fog_pkg.sv ====
package fog_pkg;

	// data path width for error, offset, rate and accumulator sums
	localparam int unsigned WORD_W = 32;

	// half-period sequence of the error demodulator
	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		// low half of the bias modulation
		WAIT_TRIG_L  = 4'd1,
		SETTLE_L     = 4'd2,
		ACQ_L        = 4'd3,
		RATE_PULSE_L = 4'd4,
		RAMP_PULSE_L = 4'd5,
		// high half of the bias modulation
		WAIT_TRIG_H  = 4'd6,
		SETTLE_H     = 4'd7,
		ACQ_H        = 4'd8,
		// end of period: error and sync pulse train
		ERR_GEN      = 4'd9,
		ERR_GEN_DLY  = 4'd10,
		RATE_PULSE_H = 4'd11,
		RAMP_PULSE_H = 4'd12
	} demod_state_e;

	// averaging selector, code n means 2**n samples per half
	typedef enum logic [2:0] {
		AVG_1  = 3'd0,
		AVG_2  = 3'd1,
		AVG_4  = 3'd2,
		AVG_8  = 3'd3,
		AVG_16 = 3'd4,
		AVG_32 = 3'd5,
		AVG_64 = 3'd6
	} avg_sel_e;

	// codes above this are clamped
	localparam int unsigned AVG_SEL_MAX = 6;

	// selector in effect out of reset
	localparam avg_sel_e AVG_SEL_RST = AVG_32;

endpackage

// ==== verilog/fog_ramp_gen.sv ====
module fog_ramp_gen #(
	parameter int RAMP_BIT   = 16,
	parameter int GAIN_SHIFT = 4
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst_n,
	input  logic signed [fog_pkg::WORD_W-1:0]     i_err,
	input  logic                                  i_step_sync_dly,
	input  logic                                  i_ramp_sync,
	output logic signed [fog_pkg::WORD_W-1:0]     o_rate,
	output logic [RAMP_BIT-1:0]                   o_ramp
);

	import fog_pkg::*;

	// loop gain as a plain right shift
	logic signed [WORD_W-1:0] err_scaled;
	logic [RAMP_BIT-1:0]      ramp_step;

	assign err_scaled = i_err >>> GAIN_SHIFT;
	assign ramp_step  = o_rate[RAMP_BIT-1:0];

	// rate integrator, once per modulation period
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_rate <= '0;
		else if (i_step_sync_dly)
			o_rate <= o_rate + err_scaled;
	end

	// serrodyne phase ramp, wraps through the natural overflow
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_ramp <= '0;
		else if (i_ramp_sync)
			o_ramp <= o_ramp + ramp_step;
	end

	a_ramp_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!$past(i_ramp_sync) |-> (o_ramp == $past(o_ramp)))
		else $error("ramp moved without a ramp sync");

endmodule

// ==== verilog/fog_top.sv ====
module fog_top #(
	parameter int ADC_BIT    = 14,
	parameter int RAMP_BIT   = 16,
	parameter int GAIN_SHIFT = 4
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_status,
	input  logic                                  i_polarity,
	input  logic                                  i_trig,
	input  logic [fog_pkg::WORD_W-1:0]            i_wait_cnt,
	input  logic signed [fog_pkg::WORD_W-1:0]     i_err_offset,
	input  logic signed [ADC_BIT-1:0]             i_adc_data,
	input  logic [2:0]                            i_avg_sel,
	output logic signed [fog_pkg::WORD_W-1:0]     o_err,
	output logic                                  o_step_sync,
	output logic                                  o_step_sync_dly,
	output logic                                  o_rate_sync,
	output logic                                  o_ramp_sync,
	output logic signed [fog_pkg::WORD_W-1:0]     o_rate,
	output logic [RAMP_BIT-1:0]                   o_ramp
);

	import fog_pkg::*;

	// registered controls from decode
	logic                     r_status;
	logic                     r_polarity;
	logic                     r_trig;
	logic [WORD_W-1:0]        r_wait_cnt;
	logic signed [WORD_W-1:0] r_err_offset;
	logic signed [WORD_W-1:0] r_adc;
	logic [6:0]               r_avg_cnt;
	logic [2:0]               r_avg_shift;

	fog_avg_decode #(
		.ADC_BIT(ADC_BIT)
	) u_decode (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_status     (i_status),
		.i_polarity   (i_polarity),
		.i_trig       (i_trig),
		.i_wait_cnt   (i_wait_cnt),
		.i_err_offset (i_err_offset),
		.i_adc_data   (i_adc_data),
		.i_avg_sel    (avg_sel_e'(i_avg_sel)),
		.o_status     (r_status),
		.o_polarity   (r_polarity),
		.o_trig       (r_trig),
		.o_wait_cnt   (r_wait_cnt),
		.o_err_offset (r_err_offset),
		.o_adc        (r_adc),
		.o_avg_cnt    (r_avg_cnt),
		.o_avg_shift  (r_avg_shift)
	);

	fog_err_demod u_demod (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_status        (r_status),
		.i_polarity      (r_polarity),
		.i_trig          (r_trig),
		.i_wait_cnt      (r_wait_cnt),
		.i_err_offset    (r_err_offset),
		.i_adc           (r_adc),
		.i_avg_cnt       (r_avg_cnt),
		.i_avg_shift     (r_avg_shift),
		.o_err           (o_err),
		.o_step_sync     (o_step_sync),
		.o_step_sync_dly (o_step_sync_dly),
		.o_rate_sync     (o_rate_sync),
		.o_ramp_sync     (o_ramp_sync)
	);

	fog_ramp_gen #(
		.RAMP_BIT   (RAMP_BIT),
		.GAIN_SHIFT (GAIN_SHIFT)
	) u_ramp (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_err           (o_err),
		.i_step_sync_dly (o_step_sync_dly),
		.i_ramp_sync     (o_ramp_sync),
		.o_rate          (o_rate),
		.o_ramp          (o_ramp)
	);

endmodule
